// File: filelist.f
+incdir+.
dac_ctrl_pkg.sv
dac_reg_decode.sv
dac_update_sequencer.sv
dac_frame_shifter.sv
dac_ctrl_top.sv
dac_ctrl_props.sv
dac_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the DAC controller testbench
VERILATOR ?= verilator
TOP       ?= dac_ctrl_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) dac_ctrl_params.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	-$(SIM) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run ended early, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dac_ctrl_tb.sv
// self-checking testbench for the DAC controller, rows of stimulus applied in a loop
// expected reads and frames come from a reference copy of the data register
`timescale 1ns/1ps
`default_nettype none

`include "dac_ctrl_params.svh"

module dac_ctrl_tb
    import dac_ctrl_pkg::*;
();

    localparam int ROW_CYCLES   = 200;
    localparam int TIMEOUT_BASE = 1000;
    localparam int FRAME_WAIT   = 200;
    localparam int QUIET_CYCLES = 200;

    typedef enum logic [2:0] {
        act_idle,
        act_write,
        act_read,
        act_gain,
        act_burst,
        act_prst
    } action_t;

    // one table row, burst uses all three data words
    typedef struct packed {
        action_t          act;
        logic [3:0]       addr;
        logic [2:0][15:0] data;
        logic             en;
        logic [15:0]      exp_rd;
        logic             exp_pulse;
        logic [1:0]       exp_count;
        logic [1:0][15:0] exp_word;
    } test_row_t;

    logic       clk;
    logic       interconnect_sreset;
    logic       peripheral_sreset;
    logic       en_mmi_ctrl;
    bus_req_t   bus_req;
    logic [7:0] gain;
    logic       gain_valid;
    bus_rsp_t   bus_rsp;
    logic       gain_updated;
    logic       initdone;
    logic       sclk;
    logic       sync_n;
    logic       sdin;

    test_row_t   rows[$];
    logic [15:0] frame_q[$];
    logic [15:0] shift_word;
    int          bit_count = 0;
    logic [31:0] rng_state;
    logic [15:0] ref_word;
    int          errors;
    int          passes;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    dac_ctrl_top i_dut (
        .clk                 (clk),
        .interconnect_sreset (interconnect_sreset),
        .peripheral_sreset   (peripheral_sreset),
        .en_mmi_ctrl         (en_mmi_ctrl),
        .bus_req             (bus_req),
        .gain                (gain),
        .gain_valid          (gain_valid),
        .bus_rsp             (bus_rsp),
        .gain_updated        (gain_updated),
        .initdone            (initdone),
        .sclk                (sclk),
        .sync_n              (sync_n),
        .sdin                (sdin)
    );

    always #2 clk = ~clk;

    // DAC samples sdin on the falling sclk edge, so do the same here
    always @(negedge sclk) begin
        if (sync_n === 1'b0) begin
            shift_word = {shift_word[14:0], sdin};
            bit_count  = bit_count + 1;
            if (bit_count == 16) begin
                frame_q.push_back(shift_word);
                bit_count = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end else begin
            passes++;
        end
    endtask

    // reference model of the data register, updated as rows are added
    task automatic add_row(input action_t act, input logic [3:0] addr, input logic en);
        test_row_t row;
        row         = '0;
        row.act     = act;
        row.addr    = addr;
        row.en      = en;
        row.data[0] = 16'(next_random());
        row.data[1] = 16'(next_random());
        row.data[2] = 16'(next_random());
        case (act)
            act_idle, act_prst: begin
                row.exp_count   = 2'd1;
                row.exp_word[0] = ref_word;
            end
            act_write: begin
                if (en && addr == `DAC_ADDR_DATA) begin
                    ref_word        = row.data[0];
                    row.exp_count   = 2'd1;
                    row.exp_word[0] = ref_word;
                end
            end
            act_read: begin
                case (addr)
                    `DAC_ADDR_VERSION: row.exp_rd = `DAC_VERSION;
                    `DAC_ADDR_DATA:    row.exp_rd = ref_word;
                    `DAC_ADDR_MMI_EN:  row.exp_rd = {15'd0, en};
                    default:           row.exp_rd = 16'd0;
                endcase
            end
            act_gain: begin
                if (!en) begin
                    ref_word[13:6]  = row.data[0][7:0];
                    row.exp_pulse   = 1'b1;
                    row.exp_count   = 2'd1;
                    row.exp_word[0] = ref_word;
                end
            end
            act_burst: begin
                // middle write merges into the follow-up frame
                if (en) begin
                    ref_word        = row.data[2];
                    row.exp_count   = 2'd2;
                    row.exp_word[0] = row.data[0];
                    row.exp_word[1] = row.data[2];
                end
            end
            default: begin
            end
        endcase
        rows.push_back(row);
    endtask

    task automatic build_table();
        int a;
        ref_word = `DAC_DEFAULT_WORD;
        add_row(act_idle, 4'd0, 1'b1);
        add_row(act_read, `DAC_ADDR_VERSION, 1'b1);
        add_row(act_read, `DAC_ADDR_DATA, 1'b1);
        add_row(act_write, `DAC_ADDR_DATA, 1'b1);
        add_row(act_read, `DAC_ADDR_DATA, 1'b1);
        add_row(act_write, `DAC_ADDR_VERSION, 1'b1);
        add_row(act_read, `DAC_ADDR_VERSION, 1'b1);
        add_row(act_write, `DAC_ADDR_MMI_EN, 1'b1);
        add_row(act_read, `DAC_ADDR_MMI_EN, 1'b1);
        add_row(act_read, `DAC_ADDR_MMI_EN, 1'b0);
        add_row(act_write, `DAC_ADDR_DATA, 1'b0);
        add_row(act_read, `DAC_ADDR_DATA, 1'b0);
        add_row(act_gain, 4'd0, 1'b0);
        add_row(act_read, `DAC_ADDR_DATA, 1'b0);
        add_row(act_gain, 4'd0, 1'b1);
        add_row(act_read, `DAC_ADDR_DATA, 1'b1);
        for (a = 3; a < 16; a++) begin
            add_row(act_read, 4'(a), 1'b1);
        end
        add_row(act_burst, `DAC_ADDR_DATA, 1'b1);
        add_row(act_read, `DAC_ADDR_DATA, 1'b1);
        add_row(act_prst, 4'd0, 1'b1);
        add_row(act_read, `DAC_ADDR_DATA, 1'b1);
    endtask

    task automatic bus_cycle(input bus_op_t op, input logic [3:0] addr,
                             input logic [15:0] wdata);
        bus_req.valid = 1'b1;
        bus_req.op    = op;
        bus_req.addr  = addr;
        bus_req.wdata = wdata;
        @(posedge clk);
        #1;
        bus_req.valid = 1'b0;
    endtask

    // wait for the expected frames, then watch for stray ones
    task automatic collect_frames(input int expected);
        int waited;
        waited = 0;
        while (frame_q.size() < expected && waited < FRAME_WAIT * expected) begin
            @(posedge clk);
            waited++;
        end
        repeat (QUIET_CYCLES) @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // row execution

    task automatic run_row(input test_row_t row);
        en_mmi_ctrl = row.en;
        case (row.act)
            act_write: bus_cycle(bus_write, row.addr, row.data[0]);
            act_read: begin
                bus_cycle(bus_read, row.addr, 16'd0);
                check_value("read valid", 16'(bus_rsp.rvalid), 16'd1);
                check_value("read data", bus_rsp.rdata, row.exp_rd);
            end
            act_gain: begin
                gain       = row.data[0][7:0];
                gain_valid = 1'b1;
                @(posedge clk);
                #1;
                gain_valid = 1'b0;
                check_value("gain_updated pulse", 16'(gain_updated), 16'(row.exp_pulse));
                @(posedge clk);
                #1;
                check_value("gain_updated after pulse", 16'(gain_updated), 16'd0);
            end
            act_burst: begin
                bus_cycle(bus_write, row.addr, row.data[0]);
                bus_cycle(bus_write, row.addr, row.data[1]);
                bus_cycle(bus_write, row.addr, row.data[2]);
            end
            act_prst: begin
                peripheral_sreset = 1'b1;
                @(posedge clk);
                #1;
                check_value("initdone in reset", 16'(initdone), 16'd0);
                peripheral_sreset = 1'b0;
            end
            default: begin
            end
        endcase
        if (row.act != act_read) begin
            collect_frames(int'(row.exp_count));
            check_value("frame count", 16'(frame_q.size()), 16'(row.exp_count));
            if (row.exp_count >= 2'd1 && frame_q.size() >= 1) begin
                check_value("first frame", frame_q[0], row.exp_word[0]);
            end
            if (row.exp_count == 2'd2 && frame_q.size() >= 2) begin
                check_value("second frame", frame_q[1], row.exp_word[1]);
            end
            if (row.act == act_idle || row.act == act_prst) begin
                check_value("initdone", 16'(initdone), 16'd1);
            end
            frame_q.delete();
        end
    endtask

    initial begin
        int      idx;
        int      err_before;
        action_t act_now;
        clk                 = 1'b0;
        interconnect_sreset = 1'b1;
        peripheral_sreset   = 1'b1;
        en_mmi_ctrl         = 1'b1;
        bus_req             = '0;
        gain                = 8'd0;
        gain_valid          = 1'b0;
        errors              = 0;
        passes              = 0;
        rng_state           = 32'hd8e4;
        build_table();
        cycle_limit = rows.size() * ROW_CYCLES + TIMEOUT_BASE;

        repeat (3) @(posedge clk);
        #1;
        interconnect_sreset = 1'b0;
        peripheral_sreset   = 1'b0;
        check_value("sync_n after reset", 16'(sync_n), 16'd1);
        check_value("sclk after reset", 16'(sclk), 16'd0);
        check_value("gain_updated after reset", 16'(gain_updated), 16'd0);
        check_value("initdone after reset", 16'(initdone), 16'd0);
        check_value("rvalid after reset", 16'(bus_rsp.rvalid), 16'd0);

        for (idx = 0; idx < rows.size(); idx++) begin
            err_before = errors;
            act_now    = rows[idx].act;
            run_row(rows[idx]);
            $display("test %0d %s: %s", idx, act_now.name(),
                     (errors == err_before) ? "ok" : "mismatch");
        end

        errors = errors + i_dut.u_props.assert_errors;
        $display("checks passed %0d, errors %0d", passes, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dac_ctrl_props.sv
// concurrent checks on the frame credit, the serial port and reset state
// bound into dac_ctrl_top so the checks see the sequencer to shifter handshake
`timescale 1ns/1ps
`default_nettype none

module dac_ctrl_props
    import dac_ctrl_pkg::*;
(
    input logic       clk,
    input logic       interconnect_sreset,
    input logic       peripheral_sreset,
    input frame_cmd_t frame_cmd,
    input logic       credit_return,
    input logic       sclk,
    input logic       sync_n
);

    // high from start until the credit comes back
    logic in_flight;
    logic any_sreset;
    int   assert_errors = 0;

    assign any_sreset = interconnect_sreset | peripheral_sreset;

    always_ff @(posedge clk) begin
        if (any_sreset) begin
            in_flight <= 1'b0;
        end else if (frame_cmd.start) begin
            in_flight <= 1'b1;
        end else if (credit_return) begin
            in_flight <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // properties

    a_one_credit: assert property (@(posedge clk) disable iff (any_sreset)
        frame_cmd.start |-> !in_flight)
    else begin
        $error("frame start issued while a frame is still in flight");
        assert_errors++;
    end

    // both resets return the serial port to idle
    a_sync_after_reset: assert property (@(posedge clk)
        any_sreset |=> sync_n)
    else begin
        $error("sync_n low in the cycle after reset");
        assert_errors++;
    end

    a_credit_pulse: assert property (@(posedge clk) disable iff (any_sreset)
        credit_return |=> !credit_return)
    else begin
        $error("credit_return held for more than one cycle");
        assert_errors++;
    end

    a_sclk_idle_low: assert property (@(posedge clk) disable iff (any_sreset)
        sync_n |-> !sclk)
    else begin
        $error("sclk high while sync_n is high");
        assert_errors++;
    end

endmodule

bind dac_ctrl_top dac_ctrl_props u_props (
    .clk                 (clk),
    .interconnect_sreset (interconnect_sreset),
    .peripheral_sreset   (peripheral_sreset),
    .frame_cmd           (frame_cmd),
    .credit_return       (credit_return),
    .sclk                (sclk),
    .sync_n              (sync_n)
);

`default_nettype wire

// File: dac_ctrl_top.sv
// DAC controller top level wiring register decode to the update sequencer and shifter
`timescale 1ns/1ps
`default_nettype none

module dac_ctrl_top
    import dac_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       interconnect_sreset,
    input  logic       peripheral_sreset,
    input  logic       en_mmi_ctrl,
    input  bus_req_t   bus_req,
    input  logic [7:0] gain,
    input  logic       gain_valid,
    output bus_rsp_t   bus_rsp,
    output logic       gain_updated,
    output logic       initdone,
    output logic       sclk,
    output logic       sync_n,
    output logic       sdin
);

    dac_word_t  dac_word;
    frame_cmd_t frame_cmd;
    logic       credit_return;
    logic       frame_sreset;

    // interconnect reset also clears the frame path
    assign frame_sreset = interconnect_sreset | peripheral_sreset;

    ////////////////////////////////////////////////////////////////////////////
    // decode, execute, result

    dac_reg_decode u_decode (
        .clk                 (clk),
        .interconnect_sreset (interconnect_sreset),
        .bus_req             (bus_req),
        .en_mmi_ctrl         (en_mmi_ctrl),
        .gain                (gain),
        .gain_valid          (gain_valid),
        .bus_rsp             (bus_rsp),
        .dac_word            (dac_word),
        .gain_updated        (gain_updated)
    );

    dac_update_sequencer u_seq (
        .clk               (clk),
        .peripheral_sreset (frame_sreset),
        .dac_word          (dac_word),
        .credit_return     (credit_return),
        .frame_cmd         (frame_cmd),
        .initdone          (initdone)
    );

    dac_frame_shifter u_shift (
        .clk               (clk),
        .peripheral_sreset (frame_sreset),
        .frame_cmd         (frame_cmd),
        .sclk              (sclk),
        .sync_n            (sync_n),
        .sdin              (sdin),
        .credit_return     (credit_return)
    );

endmodule

`default_nettype wire

// File: dac_frame_shifter.sv
// serial shifter for the DAC frame, MSB first on sclk, sync_n and sdin
// returns the credit one cycle after sync_n rises
`timescale 1ns/1ps
`default_nettype none

`include "dac_ctrl_params.svh"

module dac_frame_shifter
    import dac_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       peripheral_sreset,
    input  frame_cmd_t frame_cmd,
    output logic       sclk,
    output logic       sync_n,
    output logic       sdin,
    output logic       credit_return
);

    localparam int HALF_W = (`DAC_SCLK_HALF > 1) ? $clog2(`DAC_SCLK_HALF) : 1;
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`DAC_SCLK_HALF - 1);

    shift_state_t      state;
    logic [HALF_W-1:0] half_cnt;
    logic [3:0]        bit_cnt;
    logic [15:0]       shreg;
    logic              half_done;

    assign half_done = (half_cnt == HALF_LAST);

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            state         <= sh_idle;
            half_cnt      <= '0;
            bit_cnt       <= '0;
            sclk          <= 1'b0;
            sync_n        <= 1'b1;
            sdin          <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= 1'b0;
            half_cnt      <= half_done ? '0 : half_cnt + 1'b1;
            case (state)
                sh_idle: begin
                    half_cnt <= '0;
                    if (frame_cmd.start) begin
                        sync_n  <= 1'b0;
                        bit_cnt <= '0;
                        state   <= sh_low;
                    end
                end
                // sdin changes on the rising edge, away from the sampling edge
                sh_low: begin
                    if (half_done) begin
                        sclk  <= 1'b1;
                        sdin  <= shreg[15];
                        state <= sh_high;
                    end
                end
                sh_high: begin
                    if (half_done) begin
                        sclk    <= 1'b0;
                        bit_cnt <= bit_cnt + 4'd1;
                        state   <= (bit_cnt == 4'd15) ? sh_done : sh_low;
                    end
                end
                sh_done: begin
                    // sync_n goes high first, the credit follows a cycle later
                    if (sync_n) begin
                        credit_return <= 1'b1;
                        state         <= sh_idle;
                    end else if (half_done) begin
                        sync_n <= 1'b1;
                    end
                end
                default: state <= sh_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sh_idle && frame_cmd.start) begin
            shreg <= frame_cmd.data;
        end else if (state == sh_low && half_done) begin
            shreg <= {shreg[14:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: dac_update_sequencer.sv
// frame issue control with a single credit toward the serial shifter
// merges changes seen while a frame is in flight and sends the current word after reset
`timescale 1ns/1ps
`default_nettype none

module dac_update_sequencer
    import dac_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       peripheral_sreset,
    input  dac_word_t  dac_word,
    input  logic       credit_return,
    output frame_cmd_t frame_cmd,
    output logic       initdone
);

    // seq_idle means the credit is held here
    seq_state_t  state;
    logic        send_init;
    logic        issue;
    logic        start_q;
    logic [15:0] data_q;

    ////////////////////////////////////////////////////////////////////////////
    // issue decision

    always_comb begin
        case (state)
            seq_idle:    issue = send_init | dac_word.changed;
            // change arriving together with the returned credit goes straight out
            seq_busy:    issue = credit_return & dac_word.changed;
            seq_pending: issue = credit_return;
            default:     issue = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (peripheral_sreset) begin
            state     <= seq_idle;
            send_init <= 1'b1;
            start_q   <= 1'b0;
            initdone  <= 1'b0;
        end else begin
            start_q <= issue;
            if (issue) begin
                send_init <= 1'b0;
            end
            // first credit back after reset belongs to the default frame
            if (credit_return) begin
                initdone <= 1'b1;
            end
            case (state)
                seq_idle: begin
                    if (issue) begin
                        state <= seq_busy;
                    end
                end
                seq_busy: begin
                    if (issue) begin
                        state <= seq_busy;
                    end else if (credit_return) begin
                        state <= seq_idle;
                    end else if (dac_word.changed) begin
                        state <= seq_pending;
                    end
                end
                seq_pending: begin
                    // any number of changes collapse into this one frame
                    if (credit_return) begin
                        state <= seq_busy;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    // word is sampled at issue time, so the follow-up carries the latest value
    always_ff @(posedge clk) begin
        if (issue) begin
            data_q <= dac_word.value;
        end
    end

    assign frame_cmd = '{start: start_q, data: data_q};

endmodule

`default_nettype wire

// File: dac_reg_decode.sv
// register file and bus decode for the DAC controller
// takes bus writes or direct gain strobes depending on en_mmi_ctrl and flags changes
`timescale 1ns/1ps
`default_nettype none

`include "dac_ctrl_params.svh"

module dac_reg_decode
    import dac_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      interconnect_sreset,
    input  bus_req_t  bus_req,
    input  logic      en_mmi_ctrl,
    input  logic [7:0] gain,
    input  logic      gain_valid,
    output bus_rsp_t  bus_rsp,
    output dac_word_t dac_word,
    output logic      gain_updated
);

    logic [15:0] data_reg;
    logic        bus_wr_acc;
    logic        bus_rd;
    logic        gain_acc;
    logic        changed_q;
    logic        rvalid_q;
    logic [15:0] rdata_q;
    logic [15:0] rd_mux;

    ////////////////////////////////////////////////////////////////////////////
    // write acceptance

    // only one source owns the data register at a time
    assign bus_wr_acc = bus_req.valid && (bus_req.op == bus_write) &&
                        (bus_req.addr == `DAC_ADDR_DATA) && en_mmi_ctrl;
    assign gain_acc   = gain_valid && !en_mmi_ctrl;
    assign bus_rd     = bus_req.valid && (bus_req.op == bus_read);

    always_ff @(posedge clk) begin
        if (interconnect_sreset) begin
            data_reg     <= `DAC_DEFAULT_WORD;
            changed_q    <= 1'b0;
            gain_updated <= 1'b0;
        end else begin
            if (bus_wr_acc) begin
                data_reg <= bus_req.wdata;
            end else if (gain_acc) begin
                data_reg[`DAC_GAIN_LSB +: 8] <= gain;
            end
            changed_q    <= bus_wr_acc | gain_acc;
            gain_updated <= gain_acc;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read path, one cycle latency

    always_comb begin
        case (bus_req.addr)
            `DAC_ADDR_VERSION: rd_mux = `DAC_VERSION;
            `DAC_ADDR_DATA:    rd_mux = data_reg;
            `DAC_ADDR_MMI_EN:  rd_mux = {15'd0, en_mmi_ctrl};
            default:           rd_mux = 16'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (interconnect_sreset) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus_rd;
        end
    end

    // read data only moves when a read is presented
    always_ff @(posedge clk) begin
        if (bus_rd) begin
            rdata_q <= rd_mux;
        end
    end

    assign bus_rsp  = '{rvalid: rvalid_q, rdata: rdata_q};
    assign dac_word = '{changed: changed_q, value: data_reg};

endmodule

`default_nettype wire

// File: dac_ctrl_pkg.sv
// shared bus, frame and state types for the DAC controller blocks
`default_nettype none

package dac_ctrl_pkg;

    // register bus operation
    typedef enum logic {
        bus_read  = 1'b0,
        bus_write = 1'b1
    } bus_op_t;

    typedef struct packed {
        logic        valid;
        bus_op_t     op;
        logic [3:0]  addr;
        logic [15:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        rvalid;
        logic [15:0] rdata;
    } bus_rsp_t;

    // current register value plus a strobe for every accepted change
    typedef struct packed {
        logic        changed;
        logic [15:0] value;
    } dac_word_t;

    // one serial frame request toward the shifter
    typedef struct packed {
        logic        start;
        logic [15:0] data;
    } frame_cmd_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_busy,
        seq_pending
    } seq_state_t;

    typedef enum logic [1:0] {
        sh_idle,
        sh_low,
        sh_high,
        sh_done
    } shift_state_t;

endpackage

`default_nettype wire

// File: dac_ctrl_params.svh
// register map, reset value and serial timing constants for the DAC controller
// include in any block that needs an address, the default word or the sclk divide
`ifndef DAC_CTRL_PARAMS_SVH
`define DAC_CTRL_PARAMS_SVH

// register word addresses, anything else reads as zero
`define DAC_ADDR_VERSION 4'd0
`define DAC_ADDR_DATA    4'd1
`define DAC_ADDR_MMI_EN  4'd2

// data register contents after interconnect reset, also sent after peripheral reset
`define DAC_DEFAULT_WORD 16'd100

// read-only version register
`define DAC_VERSION      16'd1

// clk cycles per sclk half period
`define DAC_SCLK_HALF    2

// 8-bit gain field sits in bits 13 to 6 of the data word
`define DAC_GAIN_LSB     6

`endif
